// ==== rf_pkg.sv ====
// Shared widths and counts for the operand read stage
// Physical tag and data types, writeback source enum
// Forward source record used by the slots and muxes

package rf_pkg;

  // ==============================
  // Sizes
  // ==============================

  // Physical register tag width
  localparam int preg_w = 7;
  // Physical registers, one per tag value
  localparam int preg_num = 1 << preg_w;
  // Integer datapath width
  localparam int data_w = 64;

  // Producer pipes sharing the write port
  localparam int wb_src_num = 3;
  // Each pipe gives an ex1 source and a slot source
  localparam int fwd_src_num = 2 * wb_src_num;

  // ==============================
  // Types
  // ==============================

  typedef logic [preg_w-1:0] preg_t;
  typedef logic [data_w-1:0] preg_data_t;

  // Producers in round-robin order
  // Value doubles as the request/grant bit index
  typedef enum logic [1:0] {
    WB_IU0 = 2'd0,
    WB_IU1 = 2'd1,
    WB_LSU = 2'd2
  } wb_src_e;

  // One forward source, 72 bits
  // Order per read port:
  //   0 iu0 ex1, 1 iu0 slot,
  //   2 iu1 ex1, 3 iu1 slot,
  //   4 lsu ex1, 5 lsu slot
  typedef struct packed {
    logic       vld;
    preg_t      preg;
    preg_data_t data;
  } fwd_src_t;

endpackage

// ==== wb_port_if.sv ====
// Request/grant link from one writeback slot
// to the shared register-file write arbiter

`timescale 1ns/1ps

interface wb_port_if
  import rf_pkg::*;
();

  // Level, high while the slot holds a result
  logic       req;
  // Combinational, one-hot over all ports
  logic       gnt;
  // Held tag and result
  preg_t      preg;
  preg_data_t data;

  // Slot side
  modport producer (
    output req,
    output preg,
    output data,
    input  gnt
  );

  // Arbiter side
  modport arbiter (
    input  req,
    input  preg,
    input  data,
    output gnt
  );

endinterface

// ==== preg_wb_slot.sv ====
// Writeback slot for one producer pipe
// Holds a result until the write port is granted
// Exports incoming and held results as forward sources

`timescale 1ns/1ps

module preg_wb_slot
  import rf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       res_vld,
  input  preg_t      res_preg,
  input  preg_data_t res_data,
  output logic       res_ready,
  wb_port_if.producer wb,
  output fwd_src_t   ex1_fwd,
  output fwd_src_t   slot_fwd
);

  logic       slot_full;
  preg_t      slot_preg;
  preg_data_t slot_data;
  logic       res_accept;

  // ==============================
  // Accept and drain
  // ==============================

  // Free now, or frees at this edge through the grant
  assign res_ready  = !slot_full || wb.gnt;
  assign res_accept = res_vld && res_ready;

  // Valid bit
  // load wins over drain when both happen at one edge
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      slot_full <= 1'b0;
    else if (res_accept)
      slot_full <= 1'b1;
    else if (wb.gnt)
      slot_full <= 1'b0;
  end

  // Payload, only the valid bit is cleared
  always_ff @(posedge clk)
  begin
    if (res_accept)
    begin
      slot_preg <= res_preg;
      slot_data <= res_data;
    end
  end

  // ==============================
  // Write request
  // ==============================

  assign wb.req  = slot_full;
  assign wb.preg = slot_preg;
  assign wb.data = slot_data;

  // ==============================
  // Forward sources
  // ==============================

  // Result entering the pipe this cycle
  assign ex1_fwd.vld  = res_vld;
  assign ex1_fwd.preg = res_preg;
  assign ex1_fwd.data = res_data;

  // Result waiting for the write port
  assign slot_fwd.vld  = slot_full;
  assign slot_fwd.preg = slot_preg;
  assign slot_fwd.data = slot_data;

endmodule

// ==== wb_arbiter.sv ====
// Round-robin arbiter for the single register-file write port
// Picks one of three writeback slots and drives the write

`timescale 1ns/1ps

module wb_arbiter
  import rf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  wb_port_if.arbiter port_iu0,
  wb_port_if.arbiter port_iu1,
  wb_port_if.arbiter port_lsu,
  output logic       we,
  output preg_t      waddr,
  output preg_data_t wdata
);

  logic [wb_src_num-1:0] req_vec;
  logic [wb_src_num-1:0] gnt_vec;
  wb_src_e               rr_ptr;
  wb_src_e               win_src;
  logic                  win_vld;

  // Following source in round-robin order
  function automatic wb_src_e next_src(input wb_src_e cur);
    case (cur)
      WB_IU0:  next_src = WB_IU1;
      WB_IU1:  next_src = WB_LSU;
      default: next_src = WB_IU0;
    endcase
  endfunction

  // Bit index matches the enum value
  assign req_vec = {port_lsu.req, port_iu1.req, port_iu0.req};

  // ==============================
  // Pick winner
  // ==============================

  // Scan from the pointer, first requester wins
  always_comb
  begin
    wb_src_e cand;
    win_vld = 1'b0;
    win_src = WB_IU0;
    cand    = rr_ptr;
    for (int i = 0; i < wb_src_num; i++)
    begin
      if (!win_vld && req_vec[cand])
      begin
        win_vld = 1'b1;
        win_src = cand;
      end
      cand = next_src(cand);
    end
  end

  // One-hot grant, only where req is high
  always_comb
  begin
    gnt_vec = '0;
    if (win_vld)
      gnt_vec[win_src] = 1'b1;
  end

  assign port_iu0.gnt = gnt_vec[WB_IU0];
  assign port_iu1.gnt = gnt_vec[WB_IU1];
  assign port_lsu.gnt = gnt_vec[WB_LSU];

  // Pointer moves past each winner
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      rr_ptr <= WB_IU0;
    else if (win_vld)
      rr_ptr <= next_src(win_src);
  end

  // ==============================
  // Write port mux
  // ==============================

  assign we = win_vld;

  always_comb
  begin
    case (win_src)
      WB_IU1:
      begin
        waddr = port_iu1.preg;
        wdata = port_iu1.data;
      end
      WB_LSU:
      begin
        waddr = port_lsu.preg;
        wdata = port_lsu.data;
      end
      default:
      begin
        waddr = port_iu0.preg;
        wdata = port_iu0.data;
      end
    endcase
  end

endmodule

// ==== preg_file.sv ====
// Physical register file, 128 x 64
// One synchronous write port, two combinational read ports

`timescale 1ns/1ps

module preg_file
  import rf_pkg::*;
(
  input  logic       clk,
  input  logic       we,
  input  preg_t      waddr,
  input  preg_data_t wdata,
  input  preg_t      raddr0,
  input  preg_t      raddr1,
  output preg_data_t rdata0,
  output preg_data_t rdata1
);

  // ==============================
  // Storage
  // ==============================

  // One entry per physical tag
  preg_data_t mem [preg_num];

  // Write lands at the granting edge
  always_ff @(posedge clk)
  begin
    if (we)
      mem[waddr] <= wdata;
  end

  // ==============================
  // Read ports
  // ==============================

  // Same-cycle read, old value during a write to that tag
  // the slot forward covers it
  assign rdata0 = mem[raddr0];
  assign rdata1 = mem[raddr1];

endmodule

// ==== preg_fwd_mux.sv ====
// Operand forward select for one read port
// Six forward sources with register-file fallback
// Reports no-forward when the register file is used

`timescale 1ns/1ps

module preg_fwd_mux
  import rf_pkg::*;
(
  input  preg_t      src_preg,
  input  fwd_src_t   srcs [fwd_src_num],
  input  preg_data_t rf_data,
  output preg_data_t src_data,
  output logic       src_no_fwd
);

  logic [fwd_src_num-1:0] fwd_sel;
  logic                   fwd_one;
  preg_data_t             fwd_data;

  // ==============================
  // Tag match
  // ==============================

  // Valid source carrying the requested tag
  always_comb
  begin
    for (int i = 0; i < fwd_src_num; i++)
      fwd_sel[i] = srcs[i].vld && (srcs[i].preg == src_preg);
  end

  assign src_no_fwd = !(|fwd_sel);

  // Renamer keeps tags unique, so at most one hit
  assign fwd_one = $onehot(fwd_sel);

  // ==============================
  // Data select
  // ==============================

  // AND-OR over the hits
  always_comb
  begin
    fwd_data = '0;
    for (int i = 0; i < fwd_src_num; i++)
    begin
      if (fwd_sel[i])
        fwd_data = fwd_data | srcs[i].data;
    end
  end

  // No hit reads the file; a multiple hit gives zero
  always_comb
  begin
    if (src_no_fwd)
      src_data = rf_data;
    else if (fwd_one)
      src_data = fwd_data;
    else
      src_data = '0;
  end

endmodule

// ==== rf_read_top.sv ====
// Operand read stage top level
// Three writeback slots, write arbiter, register file
// and two forwarding read ports

`timescale 1ns/1ps

module rf_read_top
  import rf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       iu0_res_vld,
  input  logic       iu1_res_vld,
  input  logic       lsu_res_vld,
  input  preg_t      iu0_res_preg,
  input  preg_t      iu1_res_preg,
  input  preg_t      lsu_res_preg,
  input  preg_data_t iu0_res_data,
  input  preg_data_t iu1_res_data,
  input  preg_data_t lsu_res_data,
  output logic       iu0_res_ready,
  output logic       iu1_res_ready,
  output logic       lsu_res_ready,
  input  preg_t      src0_preg,
  input  preg_t      src1_preg,
  output preg_data_t src0_data,
  output preg_data_t src1_data,
  output logic       src0_no_fwd,
  output logic       src1_no_fwd
);

  // Six sources, ex1 then slot for each pipe
  fwd_src_t   fwd_srcs [fwd_src_num];

  logic       rf_we;
  preg_t      rf_waddr;
  preg_data_t rf_wdata;
  preg_data_t rf_rdata0;
  preg_data_t rf_rdata1;

  wb_port_if wb_iu0 ();
  wb_port_if wb_iu1 ();
  wb_port_if wb_lsu ();

  // ==============================
  // Writeback slots
  // ==============================

  preg_wb_slot u_slot_iu0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_vld   (iu0_res_vld),
    .res_preg  (iu0_res_preg),
    .res_data  (iu0_res_data),
    .res_ready (iu0_res_ready),
    .wb        (wb_iu0),
    .ex1_fwd   (fwd_srcs[0]),
    .slot_fwd  (fwd_srcs[1])
  );

  preg_wb_slot u_slot_iu1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_vld   (iu1_res_vld),
    .res_preg  (iu1_res_preg),
    .res_data  (iu1_res_data),
    .res_ready (iu1_res_ready),
    .wb        (wb_iu1),
    .ex1_fwd   (fwd_srcs[2]),
    .slot_fwd  (fwd_srcs[3])
  );

  preg_wb_slot u_slot_lsu (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_vld   (lsu_res_vld),
    .res_preg  (lsu_res_preg),
    .res_data  (lsu_res_data),
    .res_ready (lsu_res_ready),
    .wb        (wb_lsu),
    .ex1_fwd   (fwd_srcs[4]),
    .slot_fwd  (fwd_srcs[5])
  );

  // ==============================
  // Write path
  // ==============================

  wb_arbiter u_wb_arb (
    .clk      (clk),
    .rst_n    (rst_n),
    .port_iu0 (wb_iu0),
    .port_iu1 (wb_iu1),
    .port_lsu (wb_lsu),
    .we       (rf_we),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

  preg_file u_preg_file (
    .clk    (clk),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata),
    .raddr0 (src0_preg),
    .raddr1 (src1_preg),
    .rdata0 (rf_rdata0),
    .rdata1 (rf_rdata1)
  );

  // ==============================
  // Read ports
  // ==============================

  preg_fwd_mux u_fwd_src0 (
    .src_preg   (src0_preg),
    .srcs       (fwd_srcs),
    .rf_data    (rf_rdata0),
    .src_data   (src0_data),
    .src_no_fwd (src0_no_fwd)
  );

  preg_fwd_mux u_fwd_src1 (
    .src_preg   (src1_preg),
    .srcs       (fwd_srcs),
    .rf_data    (rf_rdata1),
    .src_data   (src1_data),
    .src_no_fwd (src1_no_fwd)
  );

endmodule

// ==== tb_clkgen.sv ====
// Clock and reset source for the testbench
// 40 ns clock, reset held low for four cycles

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  // Half period 20 ns
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Four rising edges inside reset, release away from the edge
  initial
  begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== rf_read_tb.sv ====
// Testbench for the operand read stage
// Reference model of slots, arbiter pointer and register file
// Directed and random stimulus table, compare tasks, bounded waits

`timescale 1ns/1ps

module rf_read_tb
  import rf_pkg::*;
();

  // One table row per clock cycle
  typedef struct packed {
    logic [2:0]       vld;
    preg_t [2:0]      preg;
    preg_data_t [2:0] data;
    preg_t            src0;
    preg_t            src1;
    preg_data_t       exp0;
    preg_data_t       exp1;
    logic             nf0;
    logic             nf1;
  } row_t;

  logic             clk;
  logic             rst_n;
  logic [2:0]       res_vld;
  preg_t [2:0]      res_preg;
  preg_data_t [2:0] res_data;
  logic [2:0]       res_ready;
  preg_t            src0_preg;
  preg_t            src1_preg;
  preg_data_t       src0_data;
  preg_data_t       src1_data;
  logic             src0_no_fwd;
  logic             src1_no_fwd;

  // Model state
  preg_data_t m_rf [preg_num];
  logic       m_known [preg_num];
  logic [2:0] m_full;
  preg_t      m_preg [wb_src_num];
  preg_data_t m_data [wb_src_num];
  logic [2:0] m_hold;
  wb_src_e    m_ptr;
  row_t       last_row;

  row_t       rows [$];
  string      names [$];

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rf_read_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .iu0_res_vld   (res_vld[0]),
    .iu1_res_vld   (res_vld[1]),
    .lsu_res_vld   (res_vld[2]),
    .iu0_res_preg  (res_preg[0]),
    .iu1_res_preg  (res_preg[1]),
    .lsu_res_preg  (res_preg[2]),
    .iu0_res_data  (res_data[0]),
    .iu1_res_data  (res_data[1]),
    .lsu_res_data  (res_data[2]),
    .iu0_res_ready (res_ready[0]),
    .iu1_res_ready (res_ready[1]),
    .lsu_res_ready (res_ready[2]),
    .src0_preg     (src0_preg),
    .src1_preg     (src1_preg),
    .src0_data     (src0_data),
    .src1_data     (src1_data),
    .src0_no_fwd   (src0_no_fwd),
    .src1_no_fwd   (src1_no_fwd)
  );

  // ==============================
  // Checks
  // ==============================

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input preg_data_t exp, input preg_data_t act);
    if (act !== exp)
      report_failure($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      report_failure($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp)
      report_failure($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  // ==============================
  // Reference model
  // ==============================

  // Recognizable word per tag for the directed rows
  function automatic preg_data_t dir_data(input preg_t t);
    return {8'hd1, 1'b0, t, 16'h5a5a, 8'h3c, 1'b0, t, 16'hc3c3};
  endfunction

  // Nearest full slot at or after the pointer
  // Returns -1 when idle
  function automatic int model_grant();
    int idx;
    int g;
    g = -1;
    for (int k = wb_src_num - 1; k >= 0; k--)
    begin
      idx = (int'(m_ptr) + k) % wb_src_num;
      if (m_full[idx])
        g = idx;
    end
    return g;
  endfunction

  // Empty slot, or one that drains at this edge
  function automatic logic [2:0] model_ready();
    logic [2:0] rdy;
    int         g;
    g = model_grant();
    for (int p = 0; p < wb_src_num; p++)
      rdy[p] = !m_full[p] || (g == p);
    return rdy;
  endfunction

  // Any live result carrying tag t
  function automatic logic tag_live(input preg_t t, input row_t r);
    logic live;
    live = 1'b0;
    for (int p = 0; p < wb_src_num; p++)
    begin
      if ((m_full[p] && m_preg[p] == t) || (r.vld[p] && r.preg[p] == t))
        live = 1'b1;
    end
    return live;
  endfunction

  // Ex1 inputs and held slots first, file otherwise
  task automatic model_read(input preg_t tag, input row_t r,
                            output preg_data_t d, output logic nf);
    int hits;
    hits = 0;
    d    = '0;
    for (int p = 0; p < wb_src_num; p++)
    begin
      if (r.vld[p] && r.preg[p] == tag)
      begin
        hits++;
        d = r.data[p];
      end
      if (m_full[p] && m_preg[p] == tag)
      begin
        hits++;
        d = m_data[p];
      end
    end
    nf = (hits == 0);
    if (hits == 0)
      d = m_rf[tag];
    else if (hits > 1)
      d = '0;
  endtask

  // Advance the model across one rising edge
  task automatic model_step(input row_t r);
    int         g;
    logic [2:0] rdy;
    g   = model_grant();
    rdy = model_ready();
    // Granted slot lands in the file and the pointer moves past it
    if (g >= 0)
    begin
      m_rf[m_preg[g]]    = m_data[g];
      m_known[m_preg[g]] = 1'b1;
      m_ptr              = wb_src_e'((g + 1) % wb_src_num);
    end
    for (int p = 0; p < wb_src_num; p++)
    begin
      m_hold[p] = r.vld[p] && !rdy[p];
      if (r.vld[p] && rdy[p])
      begin
        m_full[p] = 1'b1;
        m_preg[p] = r.preg[p];
        m_data[p] = r.data[p];
      end
      else if (g == p)
        m_full[p] = 1'b0;
    end
  endtask

  // ==============================
  // Stimulus table
  // ==============================

  task automatic add_row(input string name, input logic [2:0] vld,
                         input preg_t t0, input preg_t t1, input preg_t t2,
                         input preg_t s0, input preg_t s1,
                         input preg_data_t e0, input preg_data_t e1,
                         input logic n0, input logic n1);
    row_t r;
    r.vld     = vld;
    r.preg[0] = t0;
    r.preg[1] = t1;
    r.preg[2] = t2;
    r.data[0] = dir_data(t0);
    r.data[1] = dir_data(t1);
    r.data[2] = dir_data(t2);
    r.src0    = s0;
    r.src1    = s1;
    r.exp0    = e0;
    r.exp1    = e1;
    r.nf0     = n0;
    r.nf1     = n1;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // Expected values worked out cycle by cycle
  // vld order is lsu, iu1, iu0
  task automatic build_directed();
    // Single pipe write then file read
    add_row("rf_write_ex1",  3'b001, 5, 0, 0, 5, 5, dir_data(5), dir_data(5), 0, 0);
    add_row("rf_write_slot", 3'b000, 0, 0, 0, 5, 5, dir_data(5), dir_data(5), 0, 0);
    add_row("rf_idle",       3'b000, 0, 0, 0, 5, 5, dir_data(5), dir_data(5), 1, 1);
    add_row("rf_read",       3'b000, 0, 0, 0, 5, 5, dir_data(5), dir_data(5), 1, 1);
    // Ex1 forward on each pipe
    add_row("ex1_iu0",       3'b001, 10, 0, 0, 10, 5, dir_data(10), dir_data(5), 0, 1);
    add_row("ex1_iu1",       3'b010, 0, 11, 0, 11, 10, dir_data(11), dir_data(10), 0, 0);
    add_row("ex1_lsu",       3'b100, 0, 0, 12, 12, 11, dir_data(12), dir_data(11), 0, 0);
    add_row("ex1_drain",     3'b000, 0, 0, 0, 12, 10, dir_data(12), dir_data(10), 0, 1);
    // Contention with the pointer back at iu0
    add_row("cont_ex1",      3'b111, 20, 21, 22, 20, 22, dir_data(20), dir_data(22), 0, 0);
    add_row("cont_gnt_iu0",  3'b000, 0, 0, 0, 21, 22, dir_data(21), dir_data(22), 0, 0);
    add_row("cont_gnt_iu1",  3'b000, 0, 0, 0, 20, 21, dir_data(20), dir_data(21), 1, 0);
    add_row("cont_gnt_lsu",  3'b000, 0, 0, 0, 21, 22, dir_data(21), dir_data(22), 1, 0);
    add_row("cont_done",     3'b000, 0, 0, 0, 22, 20, dir_data(22), dir_data(20), 1, 1);
    // Back-to-back results with stalled pipes holding their inputs
    add_row("bp_0",          3'b111, 30, 31, 32, 30, 32, dir_data(30), dir_data(32), 0, 0);
    add_row("bp_1",          3'b111, 33, 34, 35, 33, 31, dir_data(33), dir_data(31), 0, 0);
    add_row("bp_2",          3'b111, 36, 34, 35, 35, 30, dir_data(35), dir_data(30), 0, 1);
    add_row("bp_3",          3'b111, 36, 37, 35, 36, 33, dir_data(36), dir_data(33), 0, 0);
    add_row("bp_4",          3'b011, 36, 37, 0, 31, 34, dir_data(31), dir_data(34), 1, 0);
    add_row("bp_5",          3'b010, 0, 37, 0, 37, 32, dir_data(37), dir_data(32), 0, 1);
    add_row("bp_drain_lsu",  3'b000, 0, 0, 0, 35, 36, dir_data(35), dir_data(36), 0, 0);
    add_row("bp_drain_iu0",  3'b000, 0, 0, 0, 37, 33, dir_data(37), dir_data(33), 0, 1);
    add_row("bp_drain_iu1",  3'b000, 0, 0, 0, 36, 37, dir_data(36), dir_data(37), 1, 0);
    add_row("bp_read_0",     3'b000, 0, 0, 0, 34, 35, dir_data(34), dir_data(35), 1, 1);
    add_row("bp_read_1",     3'b000, 0, 0, 0, 36, 37, dir_data(36), dir_data(37), 1, 1);
  endtask

  // Read a tag the model can predict
  function automatic preg_t pick_read_tag(input row_t r);
    preg_t t;
    t = preg_t'($urandom);
    for (int k = 0; k < 64; k++)
    begin
      if (!(m_known[t] || tag_live(t, r)))
        t = preg_t'($urandom);
    end
    // Tag 5 is written by the first directed rows
    if (!(m_known[t] || tag_live(t, r)))
      t = 7'd5;
    return t;
  endfunction

  // Random row from the current model state
  task automatic fill_random_row(output row_t r);
    preg_t      t;
    int         tries;
    preg_data_t d;
    logic       f;
    r = '0;
    // Stalled results stay on the inputs
    for (int p = 0; p < wb_src_num; p++)
    begin
      if (m_hold[p])
      begin
        r.vld[p]  = 1'b1;
        r.preg[p] = last_row.preg[p];
        r.data[p] = last_row.data[p];
      end
    end
    // New results with a tag not live anywhere
    for (int p = 0; p < wb_src_num; p++)
    begin
      if (!m_hold[p] && ($urandom % 3) != 0)
      begin
        tries = 0;
        t     = preg_t'($urandom);
        while (tag_live(t, r) && tries < 64)
        begin
          t = preg_t'($urandom);
          tries++;
        end
        if (!tag_live(t, r))
        begin
          r.vld[p]  = 1'b1;
          r.preg[p] = t;
          r.data[p] = {$urandom, $urandom};
        end
      end
    end
    r.src0 = pick_read_tag(r);
    r.src1 = pick_read_tag(r);
    model_read(r.src0, r, d, f);
    r.exp0 = d;
    r.nf0  = f;
    model_read(r.src1, r, d, f);
    r.exp1 = d;
    r.nf1  = f;
  endtask

  // ==============================
  // Drive and sample
  // ==============================

  task automatic apply_row(input row_t r, input string name);
    logic [2:0] exp_rdy;
    @(negedge clk);
    res_vld   = r.vld;
    res_preg  = r.preg;
    res_data  = r.data;
    src0_preg = r.src0;
    src1_preg = r.src1;
    // Half way through the low phase
    #10;
    exp_rdy = model_ready();
    check_data({name, " src0_data"}, r.exp0, src0_data);
    check_data({name, " src1_data"}, r.exp1, src1_data);
    check_flag({name, " src0_no_fwd"}, r.nf0, src0_no_fwd);
    check_flag({name, " src1_no_fwd"}, r.nf1, src1_no_fwd);
    check_ready({name, " iu0_res_ready"}, exp_rdy[0], res_ready[0]);
    check_ready({name, " iu1_res_ready"}, exp_rdy[1], res_ready[1]);
    check_ready({name, " lsu_res_ready"}, exp_rdy[2], res_ready[2]);
    model_step(r);
    last_row = r;
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 20)
    begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1)
      report_failure("Timeout waiting for reset release");
  endtask

  // Finish stalled results and drain the slots, then read back every written tag
  task automatic drain_and_readback();
    row_t r;
    int   n;
    r      = '0;
    n      = 0;
    // Stalled results stay on the inputs until accepted
    r.vld  = m_hold;
    r.preg = last_row.preg;
    r.data = last_row.data;
    @(negedge clk);
    res_vld = r.vld;
    #10;
    while ((|r.vld || !(&res_ready)) && n < 8)
    begin
      model_step(r);
      r.vld = m_hold;
      @(negedge clk);
      res_vld = r.vld;
      #10;
      n++;
    end
    if (|r.vld || !(&res_ready))
      report_failure("Timeout waiting for the writeback slots to drain");
    model_step(r);
    if (|m_full)
      report_failure("Model slots still full after the DUT drained");
    for (int t = 0; t < preg_num; t++)
    begin
      if (m_known[t])
      begin
        r.src0 = preg_t'(t);
        r.src1 = preg_t'(t);
        r.exp0 = m_rf[t];
        r.exp1 = m_rf[t];
        r.nf0  = 1'b1;
        r.nf1  = 1'b1;
        apply_row(r, $sformatf("readback_%0d", t));
      end
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================

  initial
  begin
    row_t r;
    int   n_dir;
    res_vld   = '0;
    res_preg  = '0;
    res_data  = '0;
    src0_preg = '0;
    src1_preg = '0;
    for (int i = 0; i < preg_num; i++)
      m_known[i] = 1'b0;
    m_full   = '0;
    m_hold   = '0;
    m_ptr    = WB_IU0;
    last_row = '0;
    void'($urandom(32'h1460_62c2));
    build_directed();
    n_dir = rows.size();
    wait_reset();
    // 200 random rows filled from the model as the run reaches them
    for (int i = 0; i < n_dir + 200; i++)
    begin
      if (i >= n_dir)
      begin
        fill_random_row(r);
        rows.push_back(r);
        names.push_back($sformatf("random_%0d", i - n_dir));
      end
      apply_row(rows[i], names[i]);
    end
    drain_and_readback();
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
rf_pkg.sv
wb_port_if.sv
preg_wb_slot.sv
wb_arbiter.sv
preg_file.sv
preg_fwd_mux.sv
rf_read_top.sv
tb_clkgen.sv
rf_read_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the operand read stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module rf_read_tb -f verilog.f

# The simulator exits nonzero on failure, the log decides the result
./obj_dir/Vrf_read_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
  exit 0
else
  exit 1
fi
